// File: source/rv_core_pkg.sv
package rv_core_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // rv32i major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] npc_seq    = 3'd0; // pc + 4
  localparam logic [2:0] npc_jal    = 3'd1; // pc + imm
  localparam logic [2:0] npc_jalr   = 3'd2; // alu result, bit 0 cleared
  localparam logic [2:0] npc_branch = 3'd3; // taken when alu bit 0 set
  localparam logic [2:0] npc_csr    = 3'd4; // mtvec or mepc

  localparam logic [2:0] wd_alu  = 3'd0;
  localparam logic [2:0] wd_snpc = 3'd1; // link address
  localparam logic [2:0] wd_dnpc = 3'd2; // auipc
  localparam logic [2:0] wd_mem  = 3'd3;
  localparam logic [2:0] wd_csr  = 3'd4; // old csr value

  localparam logic [3:0] alu_add    = 4'd0;
  localparam logic [3:0] alu_sub    = 4'd1;
  localparam logic [3:0] alu_sll    = 4'd2;
  localparam logic [3:0] alu_slt    = 4'd3;
  localparam logic [3:0] alu_sltu   = 4'd4;
  localparam logic [3:0] alu_xor    = 4'd5;
  localparam logic [3:0] alu_srl    = 4'd6;
  localparam logic [3:0] alu_sra    = 4'd7;
  localparam logic [3:0] alu_or     = 4'd8;
  localparam logic [3:0] alu_and    = 4'd9;
  localparam logic [3:0] alu_eq     = 4'd10;
  localparam logic [3:0] alu_ne     = 4'd11;
  localparam logic [3:0] alu_ge     = 4'd12;
  localparam logic [3:0] alu_geu    = 4'd13;
  localparam logic [3:0] alu_pass_b = 4'd14;
  localparam logic [3:0] alu_andn   = 4'd15; // operand1 & ~operand2

  localparam logic [1:0] opnd2_src2 = 2'd0;
  localparam logic [1:0] opnd2_imm  = 2'd1;
  localparam logic [1:0] opnd2_csr  = 2'd2; // operands become csr, src1

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  localparam logic [xlen-1:0] mcause_ecall = 32'd11;

  localparam logic [11:0] sys_ecall = 12'h000;
  localparam logic [11:0] sys_mret  = 12'h302;

  // load and store sizes
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

endpackage

// File: source/idu.sv
module idu import rv_core_pkg::*; (
  input  logic [31:0]     inst,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [4:0]      rd,
  output logic [xlen-1:0] imm,
  output logic            reg_wen,
  output logic [3:0]      alu_op,
  output logic [1:0]      opnd2_sel,
  output logic [2:0]      npc_sel,
  output logic [2:0]      wdata_sel,
  output logic [11:0]     csr_addr,
  output logic            csr_wen,
  output logic            is_ecall,
  output logic            is_mret,
  output logic            mem_ren,
  output logic            mem_wen,
  output logic [2:0]      mem_funct3
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [11:0]     funct12;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  function automatic logic [3:0] arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = alt ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign funct12 = inst[31:20];

  assign rs1        = inst[19:15];
  assign rs2        = inst[24:20];
  assign rd         = inst[11:7];
  assign mem_funct3 = funct3;

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm       = '0;
    reg_wen   = 1'b0;
    alu_op    = alu_add;
    opnd2_sel = opnd2_src2;
    npc_sel   = npc_seq;
    wdata_sel = wd_alu;
    csr_addr  = funct12;
    csr_wen   = 1'b0;
    is_ecall  = 1'b0;
    is_mret   = 1'b0;
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    case (opcode)
      op_lui: begin
        imm       = imm_u;
        reg_wen   = 1'b1;
        alu_op    = alu_pass_b;
        opnd2_sel = opnd2_imm;
      end
      op_auipc: begin
        imm       = imm_u;
        reg_wen   = 1'b1;
        wdata_sel = wd_dnpc;
      end
      op_jal: begin
        imm       = imm_j;
        reg_wen   = 1'b1;
        npc_sel   = npc_jal;
        wdata_sel = wd_snpc;
      end
      op_jalr: begin
        imm       = imm_i;
        reg_wen   = 1'b1;
        opnd2_sel = opnd2_imm;
        npc_sel   = npc_jalr;
        wdata_sel = wd_snpc;
      end
      op_branch: begin
        imm = imm_b;
        case (funct3)
          3'b000:  alu_op = alu_eq;
          3'b001:  alu_op = alu_ne;
          3'b100:  alu_op = alu_slt;
          3'b101:  alu_op = alu_ge;
          3'b110:  alu_op = alu_sltu;
          default: alu_op = alu_geu;
        endcase
        npc_sel = (funct3[2:1] == 2'b01) ? npc_seq : npc_branch; // 010, 011 undefined
      end
      op_load: begin
        imm       = imm_i;
        opnd2_sel = opnd2_imm;
        wdata_sel = wd_mem;
        if (funct3 == f3_b || funct3 == f3_h || funct3 == f3_w ||
            funct3 == f3_bu || funct3 == f3_hu) begin
          mem_ren = 1'b1;
          reg_wen = 1'b1;
        end
      end
      op_store: begin
        imm       = imm_s;
        opnd2_sel = opnd2_imm;
        mem_wen   = (funct3 == f3_b || funct3 == f3_h || funct3 == f3_w);
      end
      op_imm: begin
        imm       = imm_i;
        reg_wen   = 1'b1;
        opnd2_sel = opnd2_imm;
        alu_op    = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
      end
      op_reg: begin
        reg_wen = (funct7 & 7'b1011111) == 7'b0;
        alu_op  = arith_op(funct3, funct7[5]);
      end
      op_system: begin
        if (funct3 == 3'b000) begin
          if (funct12 == sys_ecall && rs1 == 5'd0 && rd == 5'd0) begin
            is_ecall = 1'b1;
            csr_addr = csr_mtvec;
            npc_sel  = npc_csr;
          end else if (funct12 == sys_mret) begin
            is_mret  = 1'b1;
            csr_addr = csr_mepc;
            npc_sel  = npc_csr;
          end
        end else if (funct3[2] == 1'b0) begin // csrrw, csrrs, csrrc
          reg_wen   = 1'b1;
          wdata_sel = wd_csr;
          opnd2_sel = opnd2_csr;
          case (funct3[1:0])
            2'b01:   alu_op = alu_pass_b;
            2'b10:   alu_op = alu_or;
            default: alu_op = alu_andn;
          endcase
          csr_wen = (funct3[1:0] == 2'b01) || (rs1 != 5'd0); // set/clear with x0 reads only
        end
      end
      default: ; // unknown opcode retires as a nop
    endcase
  end

endmodule

// File: source/regfile.sv
module regfile import rv_core_pkg::*; (
  input  logic            clock,
  input  logic            arst_n,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            reg_wen,
  input  logic [xlen-1:0] r_wdata,
  output logic [xlen-1:0] src1,
  output logic [xlen-1:0] src2
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wen && rd != 5'd0) begin // x0 never written
      regs[rd] <= r_wdata;
    end
  end

  assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: source/csr_file.sv
module csr_file import rv_core_pkg::*; (
  input  logic            clock,
  input  logic            arst_n,
  input  logic [xlen-1:0] pc,
  input  logic [11:0]     csr_addr,
  input  logic            csr_wen,
  input  logic [xlen-1:0] csr_wdata,
  input  logic            is_ecall,
  output logic [xlen-1:0] csr_rdata
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;

  always_comb begin
    case (csr_addr)
      csr_mstatus: csr_rdata = mstatus;
      csr_mtvec:   csr_rdata = mtvec;
      csr_mepc:    csr_rdata = mepc;
      csr_mcause:  csr_rdata = mcause;
      default:     csr_rdata = '0; // unimplemented csr
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (is_ecall) begin
      mepc   <= pc; // trap entry
      mcause <= mcause_ecall;
    end else if (csr_wen) begin
      case (csr_addr)
        csr_mstatus: mstatus <= csr_wdata;
        csr_mtvec:   mtvec   <= csr_wdata;
        csr_mepc:    mepc    <= csr_wdata;
        csr_mcause:  mcause  <= csr_wdata;
        default: ;
      endcase
    end
  end

endmodule

// File: source/alu.sv
module alu import rv_core_pkg::*; (
  input  logic [3:0]      alu_op,
  input  logic [xlen-1:0] operand1,
  input  logic [xlen-1:0] operand2,
  output logic [xlen-1:0] result
);

  logic [4:0] shamt;
  logic       lt;
  logic       ltu;

  assign shamt = operand2[4:0];
  assign lt    = $signed(operand1) < $signed(operand2);
  assign ltu   = operand1 < operand2;

  always_comb begin
    case (alu_op)
      alu_add:    result = operand1 + operand2;
      alu_sub:    result = operand1 - operand2;
      alu_sll:    result = operand1 << shamt;
      alu_slt:    result = {31'b0, lt};
      alu_sltu:   result = {31'b0, ltu};
      alu_xor:    result = operand1 ^ operand2;
      alu_srl:    result = operand1 >> shamt;
      alu_sra:    result = $unsigned($signed(operand1) >>> shamt);
      alu_or:     result = operand1 | operand2;
      alu_and:    result = operand1 & operand2;
      alu_eq:     result = {31'b0, operand1 == operand2};
      alu_ne:     result = {31'b0, operand1 != operand2};
      alu_ge:     result = {31'b0, !lt};
      alu_geu:    result = {31'b0, !ltu};
      alu_pass_b: result = operand2; // lui, csrrw
      alu_andn:   result = operand1 & ~operand2; // csrrc
      default:    result = '0;
    endcase
  end

endmodule

// File: source/exu.sv
module exu import rv_core_pkg::*; (
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] imm,
  input  logic [xlen-1:0] src1,
  input  logic [xlen-1:0] src2,
  input  logic [xlen-1:0] csr_rdata,
  input  logic [xlen-1:0] mem_rdata,
  input  logic [3:0]      alu_op,
  input  logic [1:0]      opnd2_sel,
  input  logic [2:0]      npc_sel,
  input  logic [2:0]      wdata_sel,
  output logic [xlen-1:0] npc,
  output logic [xlen-1:0] alu_result,
  output logic [xlen-1:0] r_wdata,
  output logic [xlen-1:0] csr_wdata
);

  logic [xlen-1:0] operand1;
  logic [xlen-1:0] operand2;
  logic [xlen-1:0] snpc;
  logic [xlen-1:0] dnpc;

  // csr ops run as csr op src1, so andn gives csr & ~src1
  assign operand1 = (opnd2_sel == opnd2_csr) ? csr_rdata : src1;

  always_comb begin
    case (opnd2_sel)
      opnd2_src2: operand2 = src2;
      opnd2_imm:  operand2 = imm;
      opnd2_csr:  operand2 = src1;
      default:    operand2 = '0;
    endcase
  end

  assign snpc = pc + 32'd4;
  assign dnpc = pc + imm;

  alu u_alu (
    .alu_op   (alu_op),
    .operand1 (operand1),
    .operand2 (operand2),
    .result   (alu_result)
  );

  always_comb begin
    case (npc_sel)
      npc_jal:    npc = dnpc;
      npc_jalr:   npc = {alu_result[xlen-1:1], 1'b0};
      npc_branch: npc = alu_result[0] ? dnpc : snpc;
      npc_csr:    npc = csr_rdata;
      default:    npc = snpc;
    endcase
  end

  always_comb begin
    case (wdata_sel)
      wd_snpc: r_wdata = snpc;
      wd_dnpc: r_wdata = dnpc;
      wd_mem:  r_wdata = mem_rdata;
      wd_csr:  r_wdata = csr_rdata;
      default: r_wdata = alu_result;
    endcase
  end

  assign csr_wdata = alu_result;

endmodule

// File: source/lsu.sv
module lsu import rv_core_pkg::*; (
  input  logic [xlen-1:0] alu_result,
  input  logic [xlen-1:0] src2,
  input  logic            mem_ren,
  input  logic            mem_wen,
  input  logic [2:0]      mem_funct3,
  input  logic [xlen-1:0] dmem_rdata,
  output logic [xlen-1:0] mem_rdata,
  output logic [xlen-1:0] dmem_addr,
  output logic            dmem_wen,
  output logic [3:0]      dmem_wstrb,
  output logic [xlen-1:0] dmem_wdata
);

  logic [1:0]      offset;
  logic [3:0]      strb;
  logic [xlen-1:0] shifted;
  logic [xlen-1:0] load_data;

  assign offset     = alu_result[1:0];
  assign dmem_addr  = {alu_result[xlen-1:2], 2'b00};
  assign dmem_wen   = mem_wen;
  assign dmem_wstrb = mem_wen ? strb : 4'b0000;

  always_comb begin
    case (mem_funct3[1:0])
      2'b00: begin
        strb       = 4'b0001 << offset;
        dmem_wdata = {4{src2[7:0]}}; // every lane, strobe picks one
      end
      2'b01: begin
        strb       = 4'b0011 << offset;
        dmem_wdata = {2{src2[15:0]}};
      end
      default: begin
        strb       = 4'b1111;
        dmem_wdata = src2;
      end
    endcase
  end

  assign shifted = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (mem_funct3)
      f3_b:    load_data = {{24{shifted[7]}}, shifted[7:0]};
      f3_h:    load_data = {{16{shifted[15]}}, shifted[15:0]};
      f3_bu:   load_data = {24'b0, shifted[7:0]};
      f3_hu:   load_data = {16'b0, shifted[15:0]};
      default: load_data = shifted; // lw
    endcase
  end

  assign mem_rdata = mem_ren ? load_data : '0;

endmodule

// File: source/core_top.sv
module core_top import rv_core_pkg::*; (
  input  logic            clock,
  input  logic            arst_n,
  input  logic [31:0]     inst,
  input  logic [xlen-1:0] dmem_rdata,
  output logic [xlen-1:0] inst_addr,
  output logic [xlen-1:0] dmem_addr,
  output logic            dmem_wen,
  output logic [3:0]      dmem_wstrb,
  output logic [xlen-1:0] dmem_wdata
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] npc;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [xlen-1:0] imm;
  logic            reg_wen;
  logic [3:0]      alu_op;
  logic [1:0]      opnd2_sel;
  logic [2:0]      npc_sel;
  logic [2:0]      wdata_sel;
  logic [11:0]     csr_addr;
  logic            csr_wen;
  logic            is_ecall;
  logic            mem_ren;
  logic            mem_wen;
  logic [2:0]      mem_funct3;
  logic [xlen-1:0] src1;
  logic [xlen-1:0] src2;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] csr_wdata;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] r_wdata;
  logic [xlen-1:0] mem_rdata;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= npc; // one instruction per cycle
    end
  end

  assign inst_addr = pc;

  idu u_idu (
    .inst       (inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .reg_wen    (reg_wen),
    .alu_op     (alu_op),
    .opnd2_sel  (opnd2_sel),
    .npc_sel    (npc_sel),
    .wdata_sel  (wdata_sel),
    .csr_addr   (csr_addr),
    .csr_wen    (csr_wen),
    .is_ecall   (is_ecall),
    .is_mret    (), // mret is fully handled by csr_addr and npc_sel
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_funct3 (mem_funct3)
  );

  regfile u_regfile (
    .clock   (clock),
    .arst_n  (arst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .reg_wen (reg_wen),
    .r_wdata (r_wdata),
    .src1    (src1),
    .src2    (src2)
  );

  csr_file u_csr_file (
    .clock     (clock),
    .arst_n    (arst_n),
    .pc        (pc),
    .csr_addr  (csr_addr),
    .csr_wen   (csr_wen),
    .csr_wdata (csr_wdata),
    .is_ecall  (is_ecall),
    .csr_rdata (csr_rdata)
  );

  exu u_exu (
    .pc         (pc),
    .imm        (imm),
    .src1       (src1),
    .src2       (src2),
    .csr_rdata  (csr_rdata),
    .mem_rdata  (mem_rdata),
    .alu_op     (alu_op),
    .opnd2_sel  (opnd2_sel),
    .npc_sel    (npc_sel),
    .wdata_sel  (wdata_sel),
    .npc        (npc),
    .alu_result (alu_result),
    .r_wdata    (r_wdata),
    .csr_wdata  (csr_wdata)
  );

  lsu u_lsu (
    .alu_result (alu_result),
    .src2       (src2),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_funct3 (mem_funct3),
    .dmem_rdata (dmem_rdata),
    .mem_rdata  (mem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wen   (dmem_wen),
    .dmem_wstrb (dmem_wstrb),
    .dmem_wdata (dmem_wdata)
  );

endmodule

// File: verif/core_model.sv
package core_model;
  import rv_core_pkg::*;

  logic [31:0] imem [256]; // program at reset_pc
  logic [31:0] dmem [256]; // data window at 0
  logic [31:0] xreg [32];
  logic [31:0] arch_pc;
  logic [31:0] arch_mstatus;
  logic [31:0] arch_mtvec;
  logic [31:0] arch_mepc;
  logic [31:0] arch_mcause;
  integer      seed;

  function automatic logic [31:0] rnd(input logic [31:0] n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic [31:0] fill_word(input int i);
    logic [31:0] t;
    t = i + 1;
    return t * 32'h9e37_79b9;
  endfunction

  function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  // stores always use x0 as base
  function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [31:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  function automatic logic [31:0] align_off(input logic [31:0] off, input logic [2:0] f3);
    logic [31:0] a;
    a = off;
    if (f3[1:0] == 2'b01) a[0] = 1'b0;
    if (f3[1:0] == 2'b10) a[1:0] = 2'b00;
    return a;
  endfunction

  // group of four: lui base, result op, store of its rd, control or store
  task automatic build_group(input int g);
    logic [31:0] r;
    logic [31:0] x;
    logic [31:0] off;
    logic [4:0]  rd;
    logic [2:0]  f3;
    int          kind;
    int          w;
    int          k;
    r = $random(seed);
    imem[g] = {r[31:12], r[0] ? 5'd1 : 5'd2, op_lui};
    r = $random(seed);
    rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
    f3 = r[14:12];
    kind = rnd(8);
    case (kind)
      0, 1: x = {(r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                 r[24:20], r[19:15], f3, rd, op_reg};
      2, 3: begin
        off = {20'b0, r[31:20]};
        if (f3 == 3'd1) off[11:5] = 7'h00;
        if (f3 == 3'd5) off[11:5] = {1'b0, r[30], 5'b0}; // srai or srli
        x = enc_i(off, r[19:15], f3, rd, op_imm);
      end
      4: begin
        k = rnd(5);
        f3 = (k == 0) ? f3_b : (k == 1) ? f3_h : (k == 2) ? f3_w : (k == 3) ? f3_bu : f3_hu;
        x = enc_i(align_off(rnd(1024), f3), 5'd0, f3, rd, op_load);
      end
      5: x = {r[31:12], rd, r[11] ? op_lui : op_auipc};
      6: begin
        f3 = rnd(3) + 1;
        if (r[11]) x = enc_i({20'b0, r[10] ? csr_mstatus : csr_mcause}, r[19:15], f3, rd, op_system);
        else       x = enc_i({20'b0, r[10] ? csr_mepc : csr_mtvec}, 5'd0, 3'b010, rd, op_system);
      end
      default: x = 32'h0;
    endcase
    if (kind == 7) begin
      imem[g+1] = {20'b0, 5'd3, op_auipc};
      imem[g+2] = enc_i(32'd9, 5'd3, 3'b000, rd, op_jalr); // odd target, lands on g+3
    end else begin
      imem[g+1] = x;
      imem[g+2] = enc_s(rnd(256) * 4, rd, f3_w);
    end
    w = rnd(4) + 1;
    if (g + 3 + w > 247) w = 247 - (g + 3);
    off = w * 4;
    case (rnd(4))
      0: begin
        k = rnd(6);
        f3 = (k < 2) ? k : k + 2;
        imem[g+3] = enc_b(off, r[24:20], r[19:15], f3);
      end
      1: imem[g+3] = enc_j(off, rd);
      2: begin
        f3 = rnd(3);
        imem[g+3] = enc_s(align_off(rnd(1024), f3), r[24:20], f3);
      end
      default: imem[g+3] = 32'h0000_0073; // ecall
    endcase
  endtask

  task automatic build_program();
    seed = 32'habfede18;
    for (int i = 0; i < 256; i++) imem[i] = 32'h0;
    imem[0] = {20'h80000, 5'd5, op_lui};
    imem[1] = enc_i(32'h3e0, 5'd5, 3'b000, 5'd5, op_imm); // handler at word 248
    imem[2] = enc_i({20'b0, csr_mtvec}, 5'd5, 3'b001, 5'd0, op_system);
    for (int g = 3; g < 247; g += 4) build_group(g);
    imem[247] = enc_j(-32'd976, 5'd0); // back to word 3
    imem[248] = enc_i({20'b0, csr_mepc}, 5'd0, 3'b010, 5'd6, op_system);
    imem[249] = enc_i({20'b0, csr_mcause}, 5'd0, 3'b010, 5'd7, op_system);
    imem[250] = enc_s(32'h3f0, 5'd7, f3_w);
    imem[251] = enc_s(32'h3f4, 5'd6, f3_w);
    imem[252] = enc_i(32'd4, 5'd6, 3'b000, 5'd6, op_imm);
    imem[253] = enc_i({20'b0, csr_mepc}, 5'd6, 3'b001, 5'd0, op_system);
    imem[254] = 32'h3020_0073; // mret
  endtask

  task automatic reset_model();
    for (int i = 0; i < 32; i++) xreg[i] = 32'h0;
    for (int i = 0; i < 256; i++) dmem[i] = fill_word(i);
    arch_pc      = reset_pc;
    arch_mstatus = 32'h0;
    arch_mtvec   = 32'h0;
    arch_mepc    = 32'h0;
    arch_mcause  = 32'h0;
  endtask

  function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] csr_read(input logic [11:0] addr);
    case (addr)
      csr_mstatus: return arch_mstatus;
      csr_mtvec:   return arch_mtvec;
      csr_mepc:    return arch_mepc;
      csr_mcause:  return arch_mcause;
      default:     return 32'h0;
    endcase
  endfunction

  // retires one instruction and reports the store it makes
  task automatic step_model(output logic st_en, output logic [31:0] st_addr,
                            output logic [3:0] st_strb, output logic [31:0] st_data);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ii;
    logic [31:0] is;
    logic [31:0] ib;
    logic [31:0] ij;
    logic [31:0] npc;
    logic [31:0] res;
    logic [31:0] ea;
    logic [31:0] sh;
    logic [31:0] cv;
    logic [31:0] nv;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        wr;
    logic        taken;
    ins = imem[arch_pc[9:2]];
    f3  = ins[14:12];
    rd  = ins[11:7];
    a   = xreg[ins[19:15]];
    b   = xreg[ins[24:20]];
    ii  = {{20{ins[31]}}, ins[31:20]};
    is  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    ib  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    ij  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    npc = arch_pc + 32'd4;
    res = 32'h0;
    wr  = 1'b0;
    st_en = 1'b0;
    st_addr = 32'h0;
    st_strb = 4'h0;
    st_data = 32'h0;
    case (ins[6:0])
      op_lui:   begin res = {ins[31:12], 12'b0}; wr = 1'b1; end
      op_auipc: begin res = arch_pc + {ins[31:12], 12'b0}; wr = 1'b1; end
      op_jal:   begin res = arch_pc + 32'd4; wr = 1'b1; npc = arch_pc + ij; end
      op_jalr:  begin res = arch_pc + 32'd4; wr = 1'b1; npc = (a + ii) & ~32'd1; end
      op_branch: begin
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = ($signed(a) < $signed(b));
          3'd5:    taken = ($signed(a) >= $signed(b));
          3'd6:    taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (taken) npc = arch_pc + ib;
      end
      op_load: begin
        ea = a + ii;
        sh = dmem[ea[9:2]] >> {ea[1:0], 3'b000};
        wr = 1'b1;
        case (f3)
          f3_b:    res = {{24{sh[7]}}, sh[7:0]};
          f3_h:    res = {{16{sh[15]}}, sh[15:0]};
          f3_w:    res = sh;
          f3_bu:   res = {24'b0, sh[7:0]};
          f3_hu:   res = {16'b0, sh[15:0]};
          default: wr = 1'b0;
        endcase
      end
      op_store: begin
        ea = a + is;
        st_en = 1'b1;
        st_addr = {ea[31:2], 2'b00};
        case (f3)
          f3_b:    begin st_strb = 4'b0001 << ea[1:0]; st_data = {4{b[7:0]}}; end
          f3_h:    begin st_strb = 4'b0011 << ea[1:0]; st_data = {2{b[15:0]}}; end
          default: begin st_strb = 4'b1111; st_data = b; end
        endcase
        for (int k = 0; k < 4; k++) begin
          if (st_strb[k]) dmem[ea[9:2]][8*k +: 8] = st_data[8*k +: 8];
        end
      end
      op_imm: begin res = arith(f3, f3 == 3'd5 && ins[30], a, ii); wr = 1'b1; end
      op_reg: begin res = arith(f3, ins[30], a, b); wr = 1'b1; end
      op_system: begin
        if (ins == 32'h0000_0073) begin
          arch_mepc   = arch_pc;
          arch_mcause = 32'd11;
          npc         = arch_mtvec;
        end else if (ins == 32'h3020_0073) begin
          npc = arch_mepc;
        end else if (f3 == 3'd1 || f3 == 3'd2 || f3 == 3'd3) begin
          cv  = csr_read(ins[31:20]);
          res = cv;
          wr  = 1'b1;
          nv  = (f3 == 3'd1) ? a : (f3 == 3'd2) ? (cv | a) : (cv & ~a);
          if (f3 == 3'd1 || ins[19:15] != 5'd0) begin
            case (ins[31:20])
              csr_mstatus: arch_mstatus = nv;
              csr_mtvec:   arch_mtvec   = nv;
              csr_mepc:    arch_mepc    = nv;
              csr_mcause:  arch_mcause  = nv;
              default: ;
            endcase
          end
        end
      end
      default: ;
    endcase
    if (wr && rd != 5'd0) xreg[rd] = res;
    arch_pc = npc;
  endtask

endpackage

// File: verif/core_tb.sv
module core_tb import rv_core_pkg::*, core_model::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int run_cycles = 4000;

  logic        clock;
  logic        arst_n;
  logic [31:0] inst;
  logic [31:0] dmem_rdata;
  logic [31:0] inst_addr;
  logic [31:0] dmem_addr;
  logic        dmem_wen;
  logic [3:0]  dmem_wstrb;
  logic [31:0] dmem_wdata;
  logic [31:0] mem [256]; // data memory seen by the DUT
  int          errors;
  int          checks;
  int          cycle;
  int          fail_cycle;

  core_top uut (
    .clock      (clock),
    .arst_n     (arst_n),
    .inst       (inst),
    .dmem_rdata (dmem_rdata),
    .inst_addr  (inst_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wen   (dmem_wen),
    .dmem_wstrb (dmem_wstrb),
    .dmem_wdata (dmem_wdata)
  );

  assign inst       = imem[inst_addr[9:2]];
  assign dmem_rdata = mem[dmem_addr[9:2]];

  always @(posedge clock) begin
    if (dmem_wen) begin
      for (int k = 0; k < 4; k++) begin
        if (dmem_wstrb[k]) mem[dmem_addr[9:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
      end
    end
  end

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      if (fail_cycle < 0) fail_cycle = cycle;
      $display("error %s: got %h expected %h in cycle %0d", name, got, exp, cycle);
    end
  endtask

  initial begin
    logic        st_en;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic [3:0]  st_strb;
    errors = 0;
    checks = 0;
    cycle = 0;
    fail_cycle = -1;
    arst_n = 1'b0;
    build_program();
    reset_model();
    for (int i = 0; i < 256; i++) mem[i] <= fill_word(i);
    repeat (10) begin
      @(negedge clock);
      compare_value("dmem_wen", {31'b0, dmem_wen}, 32'h0);
      compare_value("inst_addr", inst_addr, reset_pc);
    end
    arst_n = 1'b1;
    // lockstep until the run length or 1000 cycles past the first failure
    while (cycle < run_cycles && (fail_cycle < 0 || cycle < fail_cycle + 1000)) begin
      compare_value("inst_addr", inst_addr, arch_pc);
      step_model(st_en, st_addr, st_strb, st_data);
      compare_value("dmem_wen", {31'b0, dmem_wen}, {31'b0, st_en});
      if (st_en) begin
        compare_value("dmem_addr", dmem_addr, st_addr);
        compare_value("dmem_wstrb", {28'b0, dmem_wstrb}, {28'b0, st_strb});
        compare_value("dmem_wdata", dmem_wdata, st_data);
      end
      @(negedge clock);
      cycle++;
    end
    $display("cycles %0d, checks %0d, errors %0d", cycle, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    for (int n = 0; n < 6000; n++) @(posedge clock);
    $display("timeout: the run did not finish within 6000 cycles");
    $display("Errors found");
    $finish;
  end

endmodule

// File: project.f
source/rv_core_pkg.sv
source/idu.sv
source/regfile.sv
source/csr_file.sv
source/alu.sv
source/exu.sv
source/lsu.sv
source/core_top.sv
verif/core_model.sv
verif/core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator, pass only when the run reports no errors
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f project.f --top-module core_tb -o core_tb_sim &&
out=$(./obj_dir/core_tb_sim) &&
echo "$out" &&
echo "$out" | grep -qx "No errors" &&
echo "run passed" ||
{ echo "run failed"; exit 1; }
